//--- list.f
logic/tcp_rx_pkg.sv
logic/tcp_header_parser.sv
logic/tcp_rx_fifo.sv
logic/tcp_segment_meter.sv
logic/tcp_segment_rx.sv
test/tcp_segment_rx_monitor.sv
test/tcp_segment_rx_chk.sv
test/tcp_segment_rx_tb.sv

//--- run.sh
#!/bin/sh
# build with Verilator, run, and pass only when the log holds the pass line.
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal -Mdir obj_dir --top-module tcp_segment_rx_tb -f list.f \
    && ./obj_dir/Vtcp_segment_rx_tb > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "^SIMULATION PASSED$" sim.log && echo "test run passed" || { echo "test run failed"; exit 1; }

//--- test/tcp_segment_rx_tb.sv
`timescale 1ns/1ps
`default_nettype none

module tcp_segment_rx_tb;

    localparam int NUM_SEGS = 11;

    typedef struct packed {
        logic [31:0] seq;
        logic [31:0] ack;
        logic [7:0]  flags;
        logic [15:0] window;
        logic [3:0]  doffs;   // raw field as sent before the minimum of 5 applies.
        logic [7:0]  pay_len;
        logic [7:0]  trunc;   // bytes sent of a cut segment or 0 for a whole one.
    } seg_entry_t;

    logic        i_clk;
    logic        i_rst;
    logic [7:0]  i_tdata;
    logic        i_tvalid;
    logic        i_tlast;
    logic        o_tready;
    logic        o_short_seg;
    logic        o_seg_valid;
    logic [31:0] o_seq;
    logic [31:0] o_ack;
    logic [7:0]  o_flags;
    logic [15:0] o_window;
    logic [3:0]  o_data_offs;
    logic [15:0] o_pay_len;
    logic [15:0] o_pay_sum;

    seg_entry_t seg_table [NUM_SEGS];
    string      seg_names [NUM_SEGS];
    logic [7:0] seg_bytes [$];

    tcp_segment_rx i_tcp_segment_rx (.*);

    tcp_segment_rx_monitor i_monitor (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_seg_valid (o_seg_valid),
        .i_short_seg (o_short_seg),
        .i_tready    (o_tready),
        .i_seq       (o_seq),
        .i_ack       (o_ack),
        .i_flags     (o_flags),
        .i_window    (o_window),
        .i_data_offs (o_data_offs),
        .i_pay_len   (o_pay_len),
        .i_pay_sum   (o_pay_sum)
    );

    initial begin
        i_clk = 1'b0;
        forever #2 i_clk = ~i_clk;
    end

    initial begin
        repeat (NUM_SEGS * 200) @(posedge i_clk);
        $display("timeout: results still pending after %0d cycles", NUM_SEGS * 200);
        $display("SIMULATION FAILED");
        $finish;
    end

    // one byte per handshake, with random idle cycles in front of it.
    task automatic send_byte(input logic [7:0] data, input logic last);
        while ($urandom_range(0, 3) == 0) begin
            i_tvalid <= 1'b0;
            @(posedge i_clk);
        end
        i_tdata  <= data;
        i_tlast  <= last;
        i_tvalid <= 1'b1;
        do begin
            @(posedge i_clk);
        end while (!o_tready); // byte is held until the DUT takes it.
    endtask

    task automatic run_segment(input int idx);
        seg_entry_t  e;
        logic [3:0]  offs;
        int          hdr_len;
        int          total;
        logic [15:0] sum;
        e       = seg_table[idx];
        offs    = (e.doffs < 4'd5) ? 4'd5 : e.doffs;
        hdr_len = 4 * offs;
        sum     = '0;
        seg_bytes.delete();
        for (int k = 0; k < 4; k++) begin
            seg_bytes.push_back(8'($urandom)); // source and destination ports.
        end
        for (int k = 3; k >= 0; k--) begin
            seg_bytes.push_back(e.seq[8*k +: 8]);
        end
        for (int k = 3; k >= 0; k--) begin
            seg_bytes.push_back(e.ack[8*k +: 8]);
        end
        seg_bytes.push_back({e.doffs, 4'h0});
        seg_bytes.push_back(e.flags);
        seg_bytes.push_back(e.window[15:8]);
        seg_bytes.push_back(e.window[7:0]);
        while (seg_bytes.size() < hdr_len) begin
            seg_bytes.push_back(8'($urandom)); // checksum, urgent pointer and options.
        end
        for (int k = 0; k < e.pay_len; k++) begin
            seg_bytes.push_back(8'($urandom));
            sum = sum + 16'(seg_bytes[hdr_len + k]);
        end
        if (e.trunc != 0) begin
            total = e.trunc;
            i_monitor.expect_short();
        end else begin
            total = seg_bytes.size();
            i_monitor.expect_result(seg_names[idx], e.seq, e.ack, e.flags, e.window, offs,
                                    16'(e.pay_len), sum);
        end
        for (int k = 0; k < total; k++) begin
            send_byte(seg_bytes[k], k == total - 1);
        end
    endtask

    initial begin
        int errors;
        i_rst    = 1'b1;
        i_tdata  = '0;
        i_tvalid = 1'b0;
        i_tlast  = 1'b0;
        void'($urandom(99380));
        seg_table = '{
            '{32'h1000_0001, 32'h2000_0002, 8'h18, 16'hffff, 4'd5,  8'd12, 8'd0},
            '{32'hdead_beef, 32'h0bad_f00d, 8'h10, 16'h1234, 4'd6,  8'd9,  8'd0},
            '{32'h8000_0000, 32'h7fff_ffff, 8'h19, 16'h0200, 4'd15, 8'd20, 8'd0},
            '{32'h0000_0000, 32'hffff_ffff, 8'h10, 16'h0001, 4'd5,  8'd0,  8'd0},
            '{32'h1111_1111, 32'h2222_2222, 8'h18, 16'h0100, 4'd5,  8'd10, 8'd19},
            '{32'h3333_3333, 32'h4444_4444, 8'h18, 16'h0800, 4'd5,  8'd7,  8'd0},
            '{32'h5555_aaaa, 32'haaaa_5555, 8'h02, 16'hfaf0, 4'd8,  8'd0,  8'd0},
            '{32'h6666_6666, 32'h7777_7777, 8'h01, 16'h0000, 4'd5,  8'd4,  8'd1},
            '{32'h0123_4567, 32'h89ab_cdef, 8'h18, 16'h4000, 4'd7,  8'd30, 8'd0},
            '{32'h0f0f_0f0f, 32'hf0f0_f0f0, 8'h11, 16'h00ff, 4'd3,  8'd5,  8'd0},
            '{32'hcafe_0001, 32'hcafe_0002, 8'h18, 16'h2000, 4'd5,  8'd1,  8'd0}
        };
        seg_names = '{"basic", "opts_6", "opts_15", "no_payload", "cut_at_19", "after_cut",
                      "opts_8_empty", "cut_one", "long_payload", "offs_low", "one_byte"};
        repeat (4) @(posedge i_clk);
        i_rst <= 1'b0;
        for (int i = 0; i < NUM_SEGS; i++) begin
            run_segment(i);
        end
        i_tvalid <= 1'b0;
        i_tlast  <= 1'b0;
        while (i_monitor.pending != 0) begin
            @(posedge i_clk);
        end
        repeat (8) @(posedge i_clk);
        i_monitor.final_check();
        errors = i_monitor.error_count + i_tcp_segment_rx.chk.fail_count;
        $display("results %0d, short segments %0d, errors %0d",
                 i_monitor.result_count, i_monitor.short_count, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- test/tcp_segment_rx_chk.sv
`timescale 1ns/1ps
`default_nettype none

module tcp_segment_rx_chk (
    input logic       i_clk,
    input logic       i_rst,
    input logic       i_hdr_push,
    input logic       i_hdr_full,
    input logic       i_hdr_pop,
    input logic       i_hdr_empty,
    input logic       i_pay_pop,
    input logic       i_pay_empty,
    input logic       i_seg_valid,
    input logic       i_short_seg,
    input logic       i_tvalid,
    input logic       i_tready,
    input logic [7:0] i_tdata
);

    int fail_count = 0;

    hdr_push_room: assert property (@(posedge i_clk) disable iff (i_rst)
        !(i_hdr_push && i_hdr_full))
        else begin
            $error("header record pushed into a full FIFO");
            fail_count++;
        end

    // both FIFOs are only popped while they hold something.
    pop_not_empty: assert property (@(posedge i_clk) disable iff (i_rst)
        !(i_hdr_pop && i_hdr_empty) && !(i_pay_pop && i_pay_empty))
        else begin
            $error("pop of an empty FIFO");
            fail_count++;
        end

    seg_valid_single: assert property (@(posedge i_clk) disable iff (i_rst)
        i_seg_valid |=> !i_seg_valid)
        else begin
            $error("result pulse longer than one cycle");
            fail_count++;
        end

    short_seg_single: assert property (@(posedge i_clk) disable iff (i_rst)
        i_short_seg |=> !i_short_seg)
        else begin
            $error("short segment pulse longer than one cycle");
            fail_count++;
        end

    tdata_held: assert property (@(posedge i_clk) disable iff (i_rst)
        i_tvalid && !i_tready |=> $stable(i_tdata))
        else begin
            $error("input byte changed while stalled");
            fail_count++;
        end

endmodule

bind tcp_segment_rx tcp_segment_rx_chk chk (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_hdr_push  (hdr_push),
    .i_hdr_full  (hdr_full),
    .i_hdr_pop   (hdr_pop),
    .i_hdr_empty (hdr_empty),
    .i_pay_pop   (pay_pop),
    .i_pay_empty (pay_empty),
    .i_seg_valid (o_seg_valid),
    .i_short_seg (o_short_seg),
    .i_tvalid    (i_tvalid),
    .i_tready    (o_tready),
    .i_tdata     (i_tdata)
);

`default_nettype wire

//--- test/tcp_segment_rx_monitor.sv
`timescale 1ns/1ps
`default_nettype none

module tcp_segment_rx_monitor (
    input logic        i_clk,
    input logic        i_rst,
    input logic        i_seg_valid,
    input logic        i_short_seg,
    input logic        i_tready,
    input logic [31:0] i_seq,
    input logic [31:0] i_ack,
    input logic [7:0]  i_flags,
    input logic [15:0] i_window,
    input logic [3:0]  i_data_offs,
    input logic [15:0] i_pay_len,
    input logic [15:0] i_pay_sum
);

    // each entry packs seq, ack, flags, window, offset, length and sum in that order.
    logic [123:0] exp_q [$];
    string        name_q [$];
    logic         rst_q = 1'b1;
    int           pending = 0;
    int           error_count = 0;
    int           result_count = 0;
    int           short_count = 0;
    int           shorts_expected = 0;

    task automatic expect_result(input string tname, input logic [31:0] seq,
                                 input logic [31:0] ack, input logic [7:0] flags,
                                 input logic [15:0] window, input logic [3:0] offs,
                                 input logic [15:0] len, input logic [15:0] sum);
        exp_q.push_back({seq, ack, flags, window, offs, len, sum});
        name_q.push_back(tname);
        pending++;
    endtask

    task automatic expect_short();
        shorts_expected++;
    endtask

    task automatic compare_field(input string tname, input string field,
                                 input logic [31:0] expv, input logic [31:0] actv);
        if (expv !== actv) begin
            $display("error %s %s: expected %0h, actual %0h", tname, field, expv, actv);
            error_count++;
        end
    endtask

    task automatic final_check();
        if (exp_q.size() != 0) begin
            $display("%0d complete segments never produced a result", exp_q.size());
            error_count++;
        end
        if (short_count != shorts_expected) begin
            $display("error short_seg_count: expected %0d, actual %0d",
                     shorts_expected, short_count);
            error_count++;
        end
    endtask

    always @(posedge i_clk) begin : watch
        logic [123:0] expv;
        string        tname;
        if (rst_q && !i_rst) begin
            compare_field("reset", "tready", 32'd1, 32'(i_tready)); // empty FIFOs leave room.
        end
        rst_q = i_rst;
        if (!i_rst && i_short_seg) begin
            short_count++;
        end
        if (i_seg_valid) begin
            if (exp_q.size() == 0) begin
                $display("result pulse at %0t with no complete segment waiting", $time);
                error_count++;
            end else begin
                expv  = exp_q.pop_front();
                tname = name_q.pop_front();
                pending--;
                result_count++;
                compare_field(tname, "seq", expv[123:92], i_seq);
                compare_field(tname, "ack", expv[91:60], i_ack);
                compare_field(tname, "flags", 32'(expv[59:52]), 32'(i_flags));
                compare_field(tname, "window", 32'(expv[51:36]), 32'(i_window));
                compare_field(tname, "data_offs", 32'(expv[35:32]), 32'(i_data_offs));
                compare_field(tname, "pay_len", 32'(expv[31:16]), 32'(i_pay_len));
                compare_field(tname, "pay_sum", 32'(expv[15:0]), 32'(i_pay_sum));
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/tcp_segment_rx.sv
`timescale 1ns/1ps
`default_nettype none

module tcp_segment_rx (
    input  logic        i_clk,
    input  logic        i_rst,
    input  logic [7:0]  i_tdata,
    input  logic        i_tvalid,
    input  logic        i_tlast,
    output logic        o_tready,
    output logic        o_short_seg,
    output logic        o_seg_valid,
    output logic [31:0] o_seq,
    output logic [31:0] o_ack,
    output logic [7:0]  o_flags,
    output logic [15:0] o_window,
    output logic [3:0]  o_data_offs,
    output logic [15:0] o_pay_len,
    output logic [15:0] o_pay_sum
);

    logic                  hdr_push;
    logic                  hdr_pop;
    logic                  hdr_full;
    logic                  hdr_empty;
    tcp_rx_pkg::tcp_hdr_t  hdr_rec;
    tcp_rx_pkg::tcp_hdr_t  hdr_head;

    logic                  pay_push;
    logic                  pay_pop;
    logic                  pay_full;
    logic                  pay_empty;
    tcp_rx_pkg::pay_beat_t pay_rec;
    tcp_rx_pkg::pay_beat_t pay_head;

    tcp_header_parser parser (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_tdata     (i_tdata),
        .i_tvalid    (i_tvalid),
        .i_tlast     (i_tlast),
        .i_hdr_full  (hdr_full),
        .i_pay_full  (pay_full),
        .o_tready    (o_tready),
        .o_hdr_push  (hdr_push),
        .o_hdr_rec   (hdr_rec),
        .o_pay_push  (pay_push),
        .o_pay_rec   (pay_rec),
        .o_short_seg (o_short_seg)
    );

    // header records and payload bytes queue separately, in segment order.
    tcp_rx_fifo #(.t_entry(tcp_rx_pkg::tcp_hdr_t)) hdr_fifo (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_push  (hdr_push),
        .i_data  (hdr_rec),
        .i_pop   (hdr_pop),
        .o_data  (hdr_head),
        .o_empty (hdr_empty),
        .o_full  (hdr_full)
    );

    tcp_rx_fifo #(.t_entry(tcp_rx_pkg::pay_beat_t)) pay_fifo (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_push  (pay_push),
        .i_data  (pay_rec),
        .i_pop   (pay_pop),
        .o_data  (pay_head),
        .o_empty (pay_empty),
        .o_full  (pay_full)
    );

    tcp_segment_meter meter (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_hdr       (hdr_head),
        .i_hdr_empty (hdr_empty),
        .i_pay       (pay_head),
        .i_pay_empty (pay_empty),
        .o_hdr_pop   (hdr_pop),
        .o_pay_pop   (pay_pop),
        .o_seg_valid (o_seg_valid),
        .o_seq       (o_seq),
        .o_ack       (o_ack),
        .o_flags     (o_flags),
        .o_window    (o_window),
        .o_data_offs (o_data_offs),
        .o_pay_len   (o_pay_len),
        .o_pay_sum   (o_pay_sum)
    );

endmodule

`default_nettype wire

//--- logic/tcp_segment_meter.sv
`timescale 1ns/1ps
`default_nettype none

module tcp_segment_meter (
    input  logic                  i_clk,
    input  logic                  i_rst,
    input  tcp_rx_pkg::tcp_hdr_t  i_hdr,
    input  logic                  i_hdr_empty,
    input  tcp_rx_pkg::pay_beat_t i_pay,
    input  logic                  i_pay_empty,
    output logic                  o_hdr_pop,
    output logic                  o_pay_pop,
    output logic                  o_seg_valid,
    output logic [31:0]           o_seq,
    output logic [31:0]           o_ack,
    output logic [7:0]            o_flags,
    output logic [15:0]           o_window,
    output logic [3:0]            o_data_offs,
    output logic [15:0]           o_pay_len,
    output logic [15:0]           o_pay_sum
);

    typedef enum logic {IDLE, DRAIN} state_t;

    state_t               state;
    tcp_rx_pkg::tcp_hdr_t hdr_q;    // header of the segment being drained.
    logic [15:0]          len;
    logic [15:0]          sum;
    logic [15:0]          len_next;
    logic [15:0]          sum_next;
    logic                 seg_valid;

    assign o_hdr_pop = state == IDLE && !i_hdr_empty;
    assign o_pay_pop = state == DRAIN && !i_pay_empty;

    assign len_next = len + 16'd1;
    assign sum_next = sum + {8'd0, i_pay.data}; // wraps modulo 65536.

    assign o_seg_valid = seg_valid;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state     <= IDLE;
            seg_valid <= 1'b0;
        end else begin
            seg_valid <= 1'b0;
            case (state)
                IDLE: begin
                    if (o_hdr_pop) begin
                        if (i_hdr.no_payload) begin
                            seg_valid <= 1'b1;
                        end else begin
                            state <= DRAIN;
                        end
                    end
                end
                DRAIN: begin
                    if (o_pay_pop && i_pay.last) begin
                        seg_valid <= 1'b1;
                        state     <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // result fields load in the same cycle that raises the pulse.
    always_ff @(posedge i_clk) begin
        if (o_hdr_pop) begin
            hdr_q <= i_hdr;
            len   <= '0;
            sum   <= '0;
            if (i_hdr.no_payload) begin
                o_seq       <= i_hdr.seq;
                o_ack       <= i_hdr.ack;
                o_flags     <= i_hdr.flags;
                o_window    <= i_hdr.window;
                o_data_offs <= i_hdr.data_offs;
                o_pay_len   <= '0;
                o_pay_sum   <= '0;
            end
        end
        if (o_pay_pop) begin
            len <= len_next;
            sum <= sum_next;
            if (i_pay.last) begin
                o_seq       <= hdr_q.seq;
                o_ack       <= hdr_q.ack;
                o_flags     <= hdr_q.flags;
                o_window    <= hdr_q.window;
                o_data_offs <= hdr_q.data_offs;
                o_pay_len   <= len_next;
                o_pay_sum   <= sum_next;
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/tcp_rx_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module tcp_rx_fifo #(
    parameter type t_entry = logic [7:0]
) (
    input  logic   i_clk,
    input  logic   i_rst,
    input  logic   i_push,
    input  t_entry i_data,
    input  logic   i_pop,
    output t_entry o_data,
    output logic   o_empty,
    output logic   o_full
);

    t_entry mem [tcp_rx_pkg::FIFO_DEPTH];

    logic [tcp_rx_pkg::FIFO_AW-1:0] wr_ptr;
    logic [tcp_rx_pkg::FIFO_AW-1:0] rd_ptr;
    logic [tcp_rx_pkg::FIFO_AW:0]   count;
    logic                           do_push;
    logic                           do_pop;

    assign o_empty = count == '0;
    assign o_full  = count[tcp_rx_pkg::FIFO_AW]; // count reaches the depth only when full.

    // requests that would overflow or underflow are dropped here.
    assign do_push = i_push && !o_full;
    assign do_pop  = i_pop && !o_empty;

    assign o_data = mem[rd_ptr];

    always_ff @(posedge i_clk) begin
        if (do_push) begin
            mem[wr_ptr] <= i_data;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1; // pointers wrap on their own.
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end

            case ({do_push, do_pop})
                2'b10: begin
                    count <= count + 1'b1;
                end
                2'b01: begin
                    count <= count - 1'b1;
                end
                default: begin
                    count <= count;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- logic/tcp_header_parser.sv
`timescale 1ns/1ps
`default_nettype none

module tcp_header_parser (
    input  logic                  i_clk,
    input  logic                  i_rst,
    input  logic [7:0]            i_tdata,
    input  logic                  i_tvalid,
    input  logic                  i_tlast,
    input  logic                  i_hdr_full,
    input  logic                  i_pay_full,
    output logic                  o_tready,
    output logic                  o_hdr_push,
    output tcp_rx_pkg::tcp_hdr_t  o_hdr_rec,
    output logic                  o_pay_push,
    output tcp_rx_pkg::pay_beat_t o_pay_rec,
    output logic                  o_short_seg
);

    typedef enum logic {HEADER, PAYLOAD} state_t;

    state_t      state;
    logic [5:0]  counter;   // index of the byte being taken while in HEADER.
    logic [5:0]  hdr_last;  // index of the final header byte, options included.
    logic        take;
    logic        hdr_done;
    logic        short_seg;

    logic [31:0] seq;
    logic [31:0] ack;
    logic [3:0]  data_offs;
    logic [7:0]  flags;
    logic [15:0] window;

    // stall the source as soon as either side has no room.
    assign o_tready = !(i_hdr_full || i_pay_full);
    assign take     = i_tvalid && o_tready;

    assign hdr_last = {data_offs, 2'b00} - 6'd1;

    // the header counts as complete once the fixed 20 bytes are in; a tlast
    // inside the options still closes it, just without payload.
    assign hdr_done = (counter >= tcp_rx_pkg::HDR_MIN_BYTES - 6'd1) &&
                      (i_tlast || counter == hdr_last);

    assign o_hdr_push = take && state == HEADER && hdr_done;

    always_comb begin
        o_hdr_rec.seq        = seq;
        o_hdr_rec.ack        = ack;
        o_hdr_rec.data_offs  = data_offs;
        o_hdr_rec.flags      = flags;
        o_hdr_rec.window     = window;
        o_hdr_rec.no_payload = i_tlast; // push happens on tlast only when nothing follows.
    end

    assign o_pay_push     = take && state == PAYLOAD;
    assign o_pay_rec.data = i_tdata;
    assign o_pay_rec.last = i_tlast;

    assign o_short_seg = short_seg;

    // multi-byte fields arrive most significant byte first, so shift them in.
    always_ff @(posedge i_clk) begin
        if (take && state == HEADER) begin
            if (counter >= tcp_rx_pkg::SEQ_POS && counter < tcp_rx_pkg::SEQ_POS + 6'd4) begin
                seq <= {seq[23:0], i_tdata};
            end
            if (counter >= tcp_rx_pkg::ACK_POS && counter < tcp_rx_pkg::ACK_POS + 6'd4) begin
                ack <= {ack[23:0], i_tdata};
            end
            if (counter == tcp_rx_pkg::OFFS_POS) begin
                // HDR_MIN_BYTES[5:2] is the minimum offset in words.
                if (i_tdata[7:4] < tcp_rx_pkg::HDR_MIN_BYTES[5:2]) begin
                    data_offs <= tcp_rx_pkg::HDR_MIN_BYTES[5:2];
                end else begin
                    data_offs <= i_tdata[7:4];
                end
            end
            if (counter == tcp_rx_pkg::FLAGS_POS) begin
                flags <= i_tdata;
            end
            if (counter >= tcp_rx_pkg::WIN_POS && counter < tcp_rx_pkg::WIN_POS + 6'd2) begin
                window <= {window[7:0], i_tdata};
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state     <= HEADER;
            counter   <= '0;
            short_seg <= 1'b0;
        end else begin
            // a segment that ends inside the fixed header is dropped.
            short_seg <= take && state == HEADER && i_tlast &&
                         counter < tcp_rx_pkg::HDR_MIN_BYTES - 6'd1;

            if (take) begin
                case (state)
                    HEADER: begin
                        if (i_tlast) begin
                            counter <= '0;
                        end else if (hdr_done) begin
                            state   <= PAYLOAD;
                            counter <= '0;
                        end else begin
                            counter <= counter + 6'd1; // option bytes only advance the count.
                        end
                    end
                    PAYLOAD: begin
                        if (i_tlast) begin
                            state <= HEADER;
                        end
                    end
                    default: begin
                        state <= HEADER;
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/tcp_rx_pkg.sv
`default_nettype none

package tcp_rx_pkg;

    // byte positions inside the TCP header, counted from the first byte of the segment.
    localparam logic [5:0] HDR_MIN_BYTES = 6'd20; // header without options.
    localparam logic [5:0] SEQ_POS       = 6'd4;
    localparam logic [5:0] ACK_POS       = 6'd8;
    localparam logic [5:0] OFFS_POS      = 6'd12; // data offset in the upper nibble.
    localparam logic [5:0] FLAGS_POS     = 6'd13;
    localparam logic [5:0] WIN_POS       = 6'd14;

    // depth must stay a power of two because the FIFO derives full from the top count bit.
    localparam int FIFO_DEPTH = 16;
    localparam int FIFO_AW    = $clog2(FIFO_DEPTH);

    // one record per segment that got past its fixed header.
    typedef struct packed {
        logic [31:0] seq;
        logic [31:0] ack;
        logic [3:0]  data_offs;
        logic [7:0]  flags;
        logic [15:0] window;
        logic        no_payload; // segment ended at or before the end of its header.
    } tcp_hdr_t;

    typedef struct packed {
        logic [7:0] data;
        logic       last;
    } pay_beat_t;

endpackage

`default_nettype wire
